//--- src/histPkg.sv
`default_nettype none

package histPkg;

    // timestamp width from the TDC
    localparam int stampWidth = 8;
    // bin index width, 16 bins per histogram
    localparam int binWidth = 4;
    // pixels sharing one histogram memory
    localparam int pixelNum = 4;
    localparam int pixelWidth = 2;
    // samples per pixel in one acquisition
    localparam int samplesPerPixel = 4;
    // acquisitions per pass
    localparam int acqNum = 3;
    // count width, max count is acqNum * samplesPerPixel = 12
    localparam int countWidth = 4;

    typedef logic [stampWidth-1:0] stampT;
    typedef logic [binWidth-1:0] binT;
    typedef logic [pixelWidth-1:0] pixelT;
    typedef logic [countWidth-1:0] countT;

    // pass state, each run is followed by a two cycle drain
    typedef enum logic [1:0] {
        coarseRun,
        coarseDrain,
        fineRun,
        fineDrain
    } passE;

    // binner request into the count memory
    typedef struct packed {
        logic write;
        pixelT pixel;
        binT bin;
    } binReqT;

    // new count of a bin, one cycle after the write
    typedef struct packed {
        logic valid;
        pixelT pixel;
        binT bin;
        countT count;
    } countUpdT;

    // per-pass result, peak[0] belongs to pixel 0 and sits in the low bits
    typedef struct packed {
        logic valid;
        logic isFine;
        binT [pixelNum-1:0] peak;
    } peakResultT;

endpackage

`default_nettype wire

//--- src/acqSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module acqSequencer (
    input wire clk,
    input wire combin_res,
    input wire sampleValid,
    output logic sampleReady,
    output logic accept,
    output histPkg::pixelT pixel,
    output histPkg::passE pass,
    output logic phaseEnd,
    output logic clearAll
);

    logic [$clog2(histPkg::samplesPerPixel)-1:0] sampleCnt;
    logic [$clog2(histPkg::acqNum)-1:0] acqCnt;
    logic drainCnt;
    logic inDrain;
    logic lastSample;
    histPkg::passE nextPass;

    // only run states take samples
    assign sampleReady = (pass == histPkg::coarseRun) || (pass == histPkg::fineRun);
    assign accept = sampleValid && sampleReady;

    // last sample of the last pixel of the last acquisition
    assign lastSample = accept
                        && (sampleCnt == histPkg::samplesPerPixel - 1)
                        && (pixel == histPkg::pixelNum - 1)
                        && (acqCnt == histPkg::acqNum - 1);

    assign inDrain = (pass == histPkg::coarseDrain) || (pass == histPkg::fineDrain);

    // second drain cycle, last update has reached the tracker by now
    assign phaseEnd = inDrain && drainCnt;
    // memory valid bits and maxima drop on the same edge as the result latch
    assign clearAll = inDrain && drainCnt;

    // sample / pixel / acquisition counters
    // they wrap to zero on the last sample of a pass by themselves
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixel <= '0;
            acqCnt <= '0;
        end else if (accept) begin
            if (sampleCnt == histPkg::samplesPerPixel - 1) begin
                sampleCnt <= '0;
                if (pixel == histPkg::pixelNum - 1) begin
                    pixel <= '0;
                    if (acqCnt == histPkg::acqNum - 1) begin
                        acqCnt <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end else begin
                    pixel <= pixel + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // 0 in the first drain cycle, 1 in the second
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            drainCnt <= 1'b0;
        end else begin
            drainCnt <= inDrain && !drainCnt;
        end
    end

    // pass FSM, coarse and fine alternate forever
    always_comb begin
        nextPass = pass;
        case (pass)
            histPkg::coarseRun: if (lastSample) nextPass = histPkg::coarseDrain;
            histPkg::coarseDrain: if (drainCnt) nextPass = histPkg::fineRun;
            histPkg::fineRun: if (lastSample) nextPass = histPkg::fineDrain;
            histPkg::fineDrain: if (drainCnt) nextPass = histPkg::coarseRun;
            default: nextPass = histPkg::coarseRun;
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pass <= histPkg::coarseRun;
        end else begin
            pass <= nextPass;
        end
    end

endmodule

`default_nettype wire

//--- src/sampleBinner.sv
`timescale 1ns/100ps
`default_nettype none

module sampleBinner (
    input wire clk,
    input wire combin_res,
    input wire accept,
    input wire histPkg::stampT sample,
    input wire histPkg::pixelT pixel,
    input wire histPkg::passE pass,
    input wire histPkg::peakResultT result,
    output histPkg::binReqT binReq
);

    histPkg::stampT winStart [histPkg::pixelNum];
    histPkg::stampT curStart;
    // one extra bit catches a timestamp below the window start
    logic [histPkg::stampWidth:0] offset;
    logic inWindow;
    logic coarseRes;

    assign coarseRes = result.valid && !result.isFine;

    // window start = coarse peak bin times the window width
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < histPkg::pixelNum; p++) begin
                winStart[p] <= '0;
            end
        end else if (coarseRes) begin
            for (int p = 0; p < histPkg::pixelNum; p++) begin
                winStart[p] <= histPkg::stampT'(result.peak[p]) << histPkg::binWidth;
            end
        end
    end

    // first fine sample can land in the result's valid cycle
    // so the fresh coarse peak is forwarded past the registers
    always_comb begin
        if (coarseRes) begin
            curStart = histPkg::stampT'(result.peak[pixel]) << histPkg::binWidth;
        end else begin
            curStart = winStart[pixel];
        end
    end

    assign offset = {1'b0, sample} - {1'b0, curStart};
    // no borrow and offset below the window width
    assign inWindow = !offset[histPkg::stampWidth]
                      && (offset[histPkg::stampWidth-1:histPkg::binWidth] == '0);

    always_comb begin
        binReq.pixel = pixel;
        if (pass == histPkg::fineRun) begin
            // out of window samples are dropped, counters still move
            binReq.bin = offset[histPkg::binWidth-1:0];
            binReq.write = accept && inWindow;
        end else begin
            // coarse bin from the upper timestamp bits
            binReq.bin = sample[histPkg::stampWidth-1 -: histPkg::binWidth];
            binReq.write = accept;
        end
    end

endmodule

`default_nettype wire

//--- src/histogramRam.sv
`timescale 1ns/100ps
`default_nettype none

module histogramRam (
    input wire clk,
    input wire combin_res,
    input wire histPkg::binReqT binReq,
    input wire clearAll,
    output histPkg::countUpdT countUpd
);

    localparam int addrWidth = histPkg::pixelWidth + histPkg::binWidth;

    // one histogram of 16 bins per pixel
    histPkg::countT countMem [histPkg::pixelNum << histPkg::binWidth];
    // a cleared entry reads as zero whatever the memory holds
    logic [(histPkg::pixelNum << histPkg::binWidth)-1:0] entryValid;
    logic [addrWidth-1:0] addr;
    histPkg::countT newCount;

    logic updValid;
    histPkg::pixelT updPixel;
    histPkg::binT updBin;
    histPkg::countT updCount;

    assign addr = {binReq.pixel, binReq.bin};

    // first hit of a bin since the clear stores 1
    assign newCount = entryValid[addr] ? countMem[addr] + 1'b1 : histPkg::countT'(1);

    // flash clear between passes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            entryValid <= '0;
        end else if (clearAll) begin
            entryValid <= '0;
        end else if (binReq.write) begin
            entryValid[addr] <= 1'b1;
        end
    end

    // increment in place
    always_ff @(posedge clk) begin
        if (binReq.write) begin
            countMem[addr] <= newCount;
        end
    end

    // new count goes to the tracker one cycle later
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            updValid <= 1'b0;
        end else begin
            updValid <= binReq.write;
        end
    end

    always_ff @(posedge clk) begin
        if (binReq.write) begin
            updPixel <= binReq.pixel;
            updBin <= binReq.bin;
            updCount <= newCount;
        end
    end

    assign countUpd = '{valid: updValid, pixel: updPixel, bin: updBin, count: updCount};

endmodule

`default_nettype wire

//--- src/peakTracker.sv
`timescale 1ns/100ps
`default_nettype none

module peakTracker (
    input wire clk,
    input wire combin_res,
    input wire histPkg::countUpdT countUpd,
    input wire phaseEnd,
    input wire histPkg::passE pass,
    input wire clearAll,
    output histPkg::peakResultT result
);

    // running maximum and its bin per pixel
    histPkg::countT maxCnt [histPkg::pixelNum];
    histPkg::binT peakBin [histPkg::pixelNum];

    logic resValid;
    logic resFine;
    histPkg::binT [histPkg::pixelNum-1:0] resPeak;

    // strictly greater only, a tie keeps the bin that got there first
    // counts step by one, so this is the first bin to reach the maximum
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < histPkg::pixelNum; p++) begin
                maxCnt[p] <= '0;
                peakBin[p] <= '0;
            end
        end else if (clearAll) begin
            // empty pixel reports bin 0
            for (int p = 0; p < histPkg::pixelNum; p++) begin
                maxCnt[p] <= '0;
                peakBin[p] <= '0;
            end
        end else if (countUpd.valid && (countUpd.count > maxCnt[countUpd.pixel])) begin
            maxCnt[countUpd.pixel] <= countUpd.count;
            peakBin[countUpd.pixel] <= countUpd.bin;
        end
    end

    // single cycle result strobe, nothing holds it
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            resValid <= 1'b0;
        end else begin
            resValid <= phaseEnd;
        end
    end

    // bins are taken before the clear on the same edge wipes them
    always_ff @(posedge clk) begin
        if (phaseEnd) begin
            resFine <= (pass == histPkg::fineDrain);
            for (int p = 0; p < histPkg::pixelNum; p++) begin
                resPeak[p] <= peakBin[p];
            end
        end
    end

    assign result = '{valid: resValid, isFine: resFine, peak: resPeak};

endmodule

`default_nettype wire

//--- src/histBuilderTop.sv
`timescale 1ns/100ps
`default_nettype none

module histBuilderTop (
    input wire clk,
    input wire combin_res,
    input wire sampleValid,
    input wire histPkg::stampT sample,
    output logic sampleReady,
    output histPkg::peakResultT result
);

    logic accept;
    histPkg::pixelT pixel;
    histPkg::passE pass;
    logic phaseEnd;
    logic clearAll;
    histPkg::binReqT binReq;
    histPkg::countUpdT countUpd;

    // counters, pass FSM, handshake
    acqSequencer acqSequencer_inst (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .accept(accept),
        .pixel(pixel),
        .pass(pass),
        .phaseEnd(phaseEnd),
        .clearAll(clearAll)
    );

    // result feeds back for the fine window starts
    sampleBinner sampleBinner_inst (
        .clk(clk),
        .combin_res(combin_res),
        .accept(accept),
        .sample(sample),
        .pixel(pixel),
        .pass(pass),
        .result(result),
        .binReq(binReq)
    );

    histogramRam histogramRam_inst (
        .clk(clk),
        .combin_res(combin_res),
        .binReq(binReq),
        .clearAll(clearAll),
        .countUpd(countUpd)
    );

    peakTracker peakTracker_inst (
        .clk(clk),
        .combin_res(combin_res),
        .countUpd(countUpd),
        .phaseEnd(phaseEnd),
        .pass(pass),
        .clearAll(clearAll),
        .result(result)
    );

endmodule

`default_nettype wire

//--- dv/histBuilder_props.sv
`timescale 1ns/100ps
`default_nettype none

module histBuilderProps (
    input wire clk,
    input wire combin_res,
    input wire accept,
    input wire sampleReady,
    input wire histPkg::peakResultT result
);

    // ready only drops right after an accepted sample
    property dropAfterAccept;
        @(posedge clk) disable iff (!combin_res)
            $fell(sampleReady) |-> $past(accept);
    endproperty

    // drain is exactly two cycles
    property drainTwoCycles;
        @(posedge clk) disable iff (!combin_res)
            $fell(sampleReady) |-> ##1 !sampleReady ##1 sampleReady;
    endproperty

    // result shows up as the drain ends
    property resultAfterDrain;
        @(posedge clk) disable iff (!combin_res)
            $fell(sampleReady) |-> ##2 result.valid;
    endproperty

    // single cycle strobe
    property resultOneCycle;
        @(posedge clk) disable iff (!combin_res)
            result.valid |=> !result.valid;
    endproperty

    // no result without a drain before it
    property resultWithReadyRise;
        @(posedge clk) disable iff (!combin_res)
            result.valid |-> $rose(sampleReady);
    endproperty

    assert property (dropAfterAccept) else $error("sampleReady fell without an accept");
    assert property (drainTwoCycles) else $error("sampleReady not low for two cycles");
    assert property (resultAfterDrain) else $error("no result at the end of the drain");
    assert property (resultOneCycle) else $error("result valid longer than one cycle");
    assert property (resultWithReadyRise) else $error("result valid outside a drain end");

endmodule

bind histBuilderTop histBuilderProps histBuilderProps_inst (
    .clk(clk),
    .combin_res(combin_res),
    .accept(accept),
    .sampleReady(sampleReady),
    .result(result)
);

`default_nettype wire

//--- dv/histBuilderTb.sv
`timescale 1ns/100ps
`default_nettype none

module histBuilderTb;

    localparam int binNum = 1 << histPkg::binWidth;
    localparam int samplesPerPass = histPkg::acqNum * histPkg::pixelNum
                                    * histPkg::samplesPerPixel;
    // three frames of coarse then fine
    localparam int passTotal = 6;
    localparam int clkPeriod = 40;
    localparam int resetCycles = 10;
    // four cycles per sample plus the reset
    localparam int watchdogNs = passTotal * samplesPerPass * 4 * clkPeriod
                                + resetCycles * clkPeriod;

    logic clk;
    logic combin_res;
    logic sampleValid;
    histPkg::stampT sample;
    logic sampleReady;
    histPkg::peakResultT result;

    logic [31:0] lfsrState;
    // model of the pass in flight
    int binCount [histPkg::pixelNum][binNum];
    int maxCount [histPkg::pixelNum];
    int peakBin [histPkg::pixelNum];
    int winStart [histPkg::pixelNum];
    int target [histPkg::pixelNum];
    // expected result of the pass that just ended
    int expPeak [histPkg::pixelNum];
    logic expFine;
    int sampleIdx;
    int passIdx;
    int cycle;
    int lastCycle;
    logic pending;
    int resultsSeen;
    int errorCount;
    int curStamp;
    logic haveStamp;

    histBuilderTop histBuilderTop_inst (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sample(sample),
        .sampleReady(sampleReady),
        .result(result)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // right-shift Galois form with maximal length taps
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic int takeBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = (v << 1) | lfsrState[0];
        end
        return v;
    endfunction

    task automatic reportMismatch(input string name, input int expVal, input int actVal);
        errorCount++;
        $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
        $display("SIMULATION FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic abortWithMessage(input string what);
        errorCount++;
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "check failed");
    endtask

    // empty histograms and fresh targets per pixel
    task automatic startPass();
        for (int p = 0; p < histPkg::pixelNum; p++) begin
            maxCount[p] = 0;
            peakBin[p] = 0;
            for (int b = 0; b < binNum; b++) begin
                binCount[p][b] = 0;
            end
            if (passIdx % 2 == 0) begin
                target[p] = takeBits(8);
            end else if (passIdx == 3 && p == 3) begin
                // whole pixel lands past its window
                // even the lowest jitter stays outside
                target[p] = winStart[p] + binNum + 3;
            end else begin
                target[p] = winStart[p] + takeBits(4);
            end
        end
    endtask

    // n counts the pixel's samples within the pass
    function automatic int nextStamp(input int p, input int n);
        // two coarse bins take turns and the first one wins the tie
        if (passIdx == 4 && p == 2) begin
            return (target[p] + ((n % 2) ? 32 : 0)) & 8'hff;
        end
        if (passIdx % 2 == 0) begin
            return (target[p] + takeBits(3)) & 8'hff;
        end
        // fine jitter crosses the window edges now and then
        return (target[p] + takeBits(3) - 3) & 8'hff;
    endfunction

    task automatic modelAccept(input int p, input int ts);
        int bin;
        int off;
        logic binned;
        if (passIdx % 2 == 0) begin
            bin = ts >> (histPkg::stampWidth - histPkg::binWidth);
            binned = 1'b1;
        end else begin
            off = ts - winStart[p];
            binned = (off >= 0) && (off < binNum);
            bin = off;
        end
        if (binned) begin
            binCount[p][bin]++;
            // only a strictly greater count moves the peak
            if (binCount[p][bin] > maxCount[p]) begin
                maxCount[p] = binCount[p][bin];
                peakBin[p] = bin;
            end
        end
    endtask

    task automatic endPass();
        for (int p = 0; p < histPkg::pixelNum; p++) begin
            expPeak[p] = peakBin[p];
            if (passIdx % 2 == 0) begin
                winStart[p] = peakBin[p] * binNum;
            end
        end
        expFine = (passIdx % 2 == 1);
        passIdx++;
        sampleIdx = 0;
        pending = 1'b1;
        lastCycle = cycle;
        if (passIdx < passTotal) begin
            startPass();
        end
    endtask

    // outputs are settled at the falling edge
    task automatic observe();
        int age;
        age = cycle - lastCycle;
        if (pending && (age == 1 || age == 2)) begin
            assert (!sampleReady) else abortWithMessage("sampleReady high during the drain");
            assert (!result.valid)
                else abortWithMessage("result came before the drain ended");
        end else if (pending && age == 3) begin
            assert (result.valid) else abortWithMessage("result never came after the drain");
            assert (sampleReady)
                else abortWithMessage("sampleReady still low after the drain");
            assert (result.isFine == expFine)
                else abortWithMessage("result arrived in the wrong pass");
            for (int p = 0; p < histPkg::pixelNum; p++) begin
                assert (result.peak[p] == expPeak[p])
                    else reportMismatch($sformatf("result.peak[%0d]", p), expPeak[p],
                                        result.peak[p]);
            end
            pending = 1'b0;
            resultsSeen++;
        end else begin
            assert (sampleReady) else abortWithMessage("sampleReady low outside a drain");
            assert (!result.valid)
                else abortWithMessage("result valid outside its single cycle");
        end
    endtask

    task automatic drive();
        int p;
        int n;
        p = (sampleIdx / histPkg::samplesPerPixel) % histPkg::pixelNum;
        n = (sampleIdx / (histPkg::samplesPerPixel * histPkg::pixelNum))
            * histPkg::samplesPerPixel + sampleIdx % histPkg::samplesPerPixel;
        if (passIdx >= passTotal) begin
            sampleValid = 1'b0;
        end else begin
            // a stamp is held until the DUT takes it
            if (!haveStamp) begin
                curStamp = nextStamp(p, n);
                haveStamp = 1'b1;
            end
            // about one cycle in four idle even while not ready
            sampleValid = (takeBits(2) != 0);
            sample = histPkg::stampT'(curStamp);
            if (sampleValid && sampleReady) begin
                modelAccept(p, curStamp);
                haveStamp = 1'b0;
                sampleIdx++;
                if (sampleIdx == samplesPerPass) begin
                    endPass();
                end
            end
        end
    endtask

    initial begin
        lfsrState = 32'h51c0;
        combin_res = 1'b0;
        sampleValid = 1'b0;
        sample = '0;
        cycle = 0;
        lastCycle = -100;
        pending = 1'b0;
        passIdx = 0;
        sampleIdx = 0;
        resultsSeen = 0;
        errorCount = 0;
        curStamp = 0;
        haveStamp = 1'b0;
        for (int p = 0; p < histPkg::pixelNum; p++) begin
            winStart[p] = 0;
        end
        startPass();
        // ready high and no result while in reset
        repeat (resetCycles) begin
            @(negedge clk);
            cycle++;
            observe();
        end
        combin_res = 1'b1;
        while (resultsSeen < passTotal) begin
            @(negedge clk);
            cycle++;
            observe();
            drive();
        end
        // one more look for a stretched pulse
        @(negedge clk);
        cycle++;
        observe();
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired, the last result never came");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- filelist.f
src/histPkg.sv
src/acqSequencer.sv
src/sampleBinner.sv
src/histogramRam.sv
src/peakTracker.sv
src/histBuilderTop.sv
dv/histBuilder_props.sv
dv/histBuilderTb.sv
